//--- tb.f
+incdir+.
gps_pkg.sv
subchannel_cfg.sv
ca_code_gen.sv
correlator.sv
gps_subchannel.sv
tb_gps_subchannel.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_gps_subchannel
FILELIST  = tb.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = RESULT: PASS

.PHONY: sim clean

# Build, run, then decide on the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_gps_subchannel.sv
`timescale 1ns/1ps
`include "gps_defines.svh"

module tb_gps_subchannel;

   localparam int code_len        = int'(`GPS_CODE_LEN);
   localparam int last_phase      = code_len - 1;
   localparam int prn_rounds      = 4;
   localparam int seek_rounds     = 2;
   localparam int watchdog_cycles = 40 * code_len + seek_rounds * code_len + 16;

   logic                   clk_sample   = 1'b0;
   logic                   rst;
   logic                   cfg_valid;
   logic [`GPS_CFG_AW-1:0] cfg_addr;
   logic [`GPS_CFG_DW-1:0] cfg_data;
   logic                   sample_valid = 1'b0;
   gps_pkg::sample_t       sample_data  = '0;
   logic                   dump_ready   = 1'b0;
   logic                   cfg_ready;
   logic                   sample_ready;
   logic                   dump_valid;
   gps_pkg::acc_t          dump_acc;
   gps_pkg::phase_t        code_phase;
   logic                   ca_chip;

   logic [31:0]   rnd_state   = 32'h3c9c60db;
   logic [31:0]   rnd_word    = '0;      // New random word each cycle
   logic          stream_on   = 1'b0;    // Offer samples
   logic          hold_dump   = 1'b0;    // Force dump_ready low
   logic          drain_dumps = 1'b0;    // Force dump_ready high
   logic          sample_go   = 1'b0;    // Sample handshake at next rising edge
   logic          held_valid  = 1'b0;    // Dump seen waiting last cycle
   gps_pkg::acc_t held_acc    = '0;

   // G2 phase selector stages from PRN 1 up
   int tap_a [32] = '{2, 3, 4, 5, 1, 2, 1, 2, 3, 2, 3, 5, 6, 7, 8, 9,
                      1, 2, 3, 4, 5, 6, 1, 4, 5, 6, 7, 8, 1, 2, 3, 4};
   int tap_b [32] = '{6, 7, 8, 9, 9, 10, 8, 9, 10, 3, 4, 6, 7, 8, 9, 10,
                      4, 5, 6, 7, 8, 9, 3, 6, 7, 8, 9, 10, 6, 7, 8, 9};

   bit [1:10] g1_m        = '1;          // Stage 1 takes the feedback
   bit [1:10] g2_m        = '1;
   int        prn_m       = 1;
   int        phase_m     = 0;
   int        sum_m       = 0;
   bit        chip_m;
   int        exp_q [$];                 // Sums still owed by the DUT
   int        epochs_seen = 0;
   int        dumps_seen  = 0;
   int        stall_hits  = 0;           // Epoch end met a pending dump

   gps_subchannel gps_subchannel_i (.*);

   always #10 clk_sample = ~clk_sample;

   function automatic logic [31:0] lcg_next();
      rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
      return rnd_state;
   endfunction

   function automatic int sample_value(input gps_pkg::sample_t s);
      int m;
      m = 2 * int'(s[1:0]) + 1;
      return s[2] ? -m : m;              // Sign bit set is negative
   endfunction

   function automatic bit model_chip();
      return g1_m[10] ^ g2_m[tap_a[prn_m - 1]] ^ g2_m[tap_b[prn_m - 1]];
   endfunction

   function automatic void model_step();
      bit fb1;
      bit fb2;
      fb1     = g1_m[3] ^ g1_m[10];
      fb2     = g2_m[2] ^ g2_m[3] ^ g2_m[6] ^ g2_m[8] ^ g2_m[9] ^ g2_m[10];
      g1_m    = {fb1, g1_m[1:9]};
      g2_m    = {fb2, g2_m[1:9]};
      phase_m = (phase_m == last_phase) ? 0 : phase_m + 1;
   endfunction

   function automatic void model_reload(input gps_pkg::prn_t p);
      prn_m   = (p == 5'd0) ? 32 : int'(p);  // Code 0 selects PRN 32
      g1_m    = '1;
      g2_m    = '1;
      phase_m = 0;
      sum_m   = 0;                           // Partial epoch thrown away
   endfunction

   function automatic void apply_write(input logic [`GPS_CFG_AW-1:0] addr,
                                       input logic [`GPS_CFG_DW-1:0] data);
      int target;
      target = int'(data[`GPS_PHASE_W-1:0]);
      if (addr == `GPS_REG_PRN) begin
         model_reload(data[4:0]);
      end else if (addr == `GPS_REG_SEEK) begin
         while (phase_m != target) begin
            model_step();                    // Slew without samples
         end
         sum_m = 0;
      end
   endfunction

   task automatic check_value(input string name, input int expected, input int actual);
      if (expected != actual) begin
         $display("** Error at %0t: %s expected %0d, actual %0d", $time, name, expected, actual);
         $display("RESULT: FAIL");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   task automatic abort_run(input string why);
      $display("Failure at %0t: %s", $time, why);
      $display("RESULT: FAIL");
      $fatal(1, "%s", why);
   endtask

   task automatic write_cfg(input logic [`GPS_CFG_AW-1:0] addr,
                            input logic [`GPS_CFG_DW-1:0] data);
      @(posedge clk_sample);
      cfg_valid <= 1'b1;
      cfg_addr  <= addr;
      cfg_data  <= data;
      @(negedge clk_sample);
      while (!cfg_ready) begin
         @(negedge clk_sample);
      end
      @(posedge clk_sample);                 // Write taken on this edge
      cfg_valid <= 1'b0;
   endtask

   task automatic write_prn(input gps_pkg::prn_t p);
      write_cfg(`GPS_REG_PRN, {11'd0, p});
      repeat (2) @(negedge clk_sample);      // Past the load pulse
      check_value("code_phase", 0, int'(code_phase));
   endtask

   task automatic wait_epochs(input int n);
      int goal;
      goal = epochs_seen + n;
      while (epochs_seen < goal) begin
         @(negedge clk_sample);
      end
   endtask

   task automatic wait_samples(input int n);
      repeat (n) begin
         @(negedge clk_sample);
         while (!sample_go) begin
            @(negedge clk_sample);
         end
      end
   endtask

   // Random sample source holding data until taken
   always @(posedge clk_sample) begin
      if (!rst) begin
         rnd_word = lcg_next();
         if (!sample_valid || sample_go) begin
            sample_valid <= stream_on && (rnd_word[31:29] != 3'd0);  // 7 of 8
            sample_data  <= rnd_word[20:18];
         end
         dump_ready <= drain_dumps || (!hold_dump && (rnd_word[15:14] != 2'd0));
      end
   end

   // Monitor and reference model on settled inputs
   always @(negedge clk_sample) begin
      if (!rst) begin
         sample_go = sample_valid && sample_ready;
         if (held_valid) begin
            check_value("dump_valid", 1, int'(dump_valid));   // Must wait for ready
            check_value("dump_acc", int'(held_acc), int'(dump_acc));
         end
         held_valid = dump_valid && !dump_ready;
         held_acc   = dump_acc;
         if (!cfg_ready) begin
            check_value("sample_ready", 0, int'(sample_ready));  // Seek in progress
         end
         if (dump_valid && int'(code_phase) == last_phase) begin
            check_value("sample_ready", 0, int'(sample_ready));
            if (sample_valid) begin
               stall_hits++;
            end
         end
         if (dump_valid && dump_ready) begin    // Older dump leaves first
            if (exp_q.size() == 0) begin
               abort_run("DUT delivered a dump that no epoch produced");
            end else begin
               check_value("dump_acc", exp_q.pop_front(), int'(dump_acc));
               dumps_seen++;
            end
         end
         if (sample_go) begin
            chip_m = model_chip();
            check_value("code_phase", phase_m, int'(code_phase));
            check_value("ca_chip", int'(chip_m), int'(ca_chip));
            sum_m += chip_m ? sample_value(sample_data) : -sample_value(sample_data);
            if (phase_m == last_phase) begin
               exp_q.push_back(sum_m);          // Epoch closes here
               sum_m = 0;
               epochs_seen++;
            end
            model_step();
         end
         if (cfg_valid && cfg_ready) begin
            apply_write(cfg_addr, cfg_data);   // After a same-edge sample
         end
      end
   end

   initial begin
      repeat (watchdog_cycles) @(posedge clk_sample);
      $display("Timeout: test still running after %0d cycles", watchdog_cycles);
      $display("RESULT: FAIL");
      $fatal(1, "Watchdog expired");
   end

   initial begin
      int target;
      rst       = 1'b1;
      cfg_valid = 1'b0;
      cfg_addr  = '0;
      cfg_data  = '0;
      repeat (16) @(posedge clk_sample);
      rst <= 1'b0;
      @(negedge clk_sample);
      check_value("cfg_ready", 1, int'(cfg_ready));
      check_value("sample_ready", 0, int'(sample_ready));
      check_value("dump_valid", 0, int'(dump_valid));
      check_value("code_phase", 0, int'(code_phase));

      write_prn(5'd1);                          // PRN 1 over two periods
      write_cfg(`GPS_REG_CTRL, 16'd1);
      @(negedge clk_sample);
      stream_on = 1'b1;
      wait_epochs(2);

      repeat (prn_rounds) begin                 // New satellite mid epoch
         wait_samples(100 + int'(rnd_word % 32'd800));
         write_prn(5'(rnd_word >> 7));
         wait_epochs(1);
      end

      repeat (seek_rounds) begin
         wait_samples(50 + int'(rnd_word % 32'd500));
         target = int'(rnd_word % 32'd1023);
         write_cfg(`GPS_REG_SEEK, 16'(target));
         @(negedge clk_sample);
         check_value("cfg_ready", 0, int'(cfg_ready));
         while (!cfg_ready) begin
            @(negedge clk_sample);
         end
         check_value("code_phase", target, int'(code_phase));
         wait_epochs(1);                        // Partial sum from target on
      end

      hold_dump = 1'b1;                         // Let the next epoch end pile up
      while (!(dump_valid && int'(code_phase) == last_phase)) begin
         @(negedge clk_sample);
      end
      repeat (20) @(negedge clk_sample);
      hold_dump = 1'b0;
      wait_epochs(2);

      stream_on   = 1'b0;
      drain_dumps = 1'b1;
      repeat (4) @(negedge clk_sample);
      while (exp_q.size() != 0 || dump_valid) begin
         @(negedge clk_sample);
      end

      if (stall_hits > 0 && dumps_seen == epochs_seen) begin
         $display("RESULT: PASS");
         $finish;
      end else begin
         $display("Dumps %0d of %0d epochs, back-pressure hits %0d",
                  dumps_seen, epochs_seen, stall_hits);
         $display("RESULT: FAIL");
         $fatal(1, "Dump count or back-pressure coverage wrong");
      end
   end

endmodule

//--- gps_subchannel.sv
`timescale 1ns/1ps
`include "gps_defines.svh"

module gps_subchannel (
   input  logic                   clk_sample,
   input  logic                   rst,
   input  logic                   cfg_valid,
   input  logic [`GPS_CFG_AW-1:0] cfg_addr,
   input  logic [`GPS_CFG_DW-1:0] cfg_data,
   input  logic                   sample_valid,
   input  gps_pkg::sample_t       sample_data,
   input  logic                   dump_ready,
   output logic                   cfg_ready,
   output logic                   sample_ready,
   output logic                   dump_valid,
   output gps_pkg::acc_t          dump_acc,
   output gps_pkg::phase_t        code_phase,
   output logic                   ca_chip
);

   gps_pkg::prn_t   prn;
   gps_pkg::phase_t seek_target;
   logic            prn_load;
   logic            seek_start;
   logic            seek_busy;
   logic            seek_done;
   logic            enable;
   logic            advance;
   logic            clear;

   assign clear = prn_load | seek_done;   // Both restart the epoch sum

   subchannel_cfg cfg_i (
      .clk_sample  (clk_sample),
      .rst         (rst),
      .cfg_valid   (cfg_valid),
      .cfg_addr    (cfg_addr),
      .cfg_data    (cfg_data),
      .seek_busy   (seek_busy),
      .cfg_ready   (cfg_ready),
      .prn         (prn),
      .prn_load    (prn_load),
      .seek_target (seek_target),
      .seek_start  (seek_start),
      .enable      (enable)
   );

   ca_code_gen code_gen_i (
      .clk_sample  (clk_sample),
      .rst         (rst),
      .prn         (prn),
      .prn_load    (prn_load),
      .seek_target (seek_target),
      .seek_start  (seek_start),
      .advance     (advance),
      .ca_chip     (ca_chip),
      .code_phase  (code_phase),
      .seek_busy   (seek_busy),
      .seek_done   (seek_done)
   );

   correlator corr_i (
      .clk_sample   (clk_sample),
      .rst          (rst),
      .enable       (enable),
      .seek_busy    (seek_busy),
      .clear        (clear),
      .sample_valid (sample_valid),
      .sample_data  (sample_data),
      .ca_chip      (ca_chip),
      .code_phase   (code_phase),
      .dump_ready   (dump_ready),
      .sample_ready (sample_ready),
      .advance      (advance),
      .dump_valid   (dump_valid),
      .dump_acc     (dump_acc)
   );

endmodule

//--- correlator.sv
`timescale 1ns/1ps
`include "gps_defines.svh"

module correlator (
   input  logic             clk_sample,
   input  logic             rst,
   input  logic             enable,
   input  logic             seek_busy,
   input  logic             clear,         // PRN load or seek end
   input  logic             sample_valid,
   input  gps_pkg::sample_t sample_data,
   input  logic             ca_chip,       // 1 is +1, 0 is -1
   input  gps_pkg::phase_t  code_phase,
   input  logic             dump_ready,
   output logic             sample_ready,
   output logic             advance,       // Sample taken this edge
   output logic             dump_valid,
   output gps_pkg::acc_t    dump_acc
);

   localparam gps_pkg::phase_t last_phase = gps_pkg::phase_t'(`GPS_CODE_LEN - 1);

   gps_pkg::acc_t     acc;          // Running sum of this epoch
   gps_pkg::acc_t     acc_next;     // Sum including current sample
   logic [2:0]        mag;          // 2m+1
   logic              neg;          // Sign of the product
   logic signed [3:0] prod;         // -7..+7
   logic              last_chip;
   logic              epoch_hold;
   logic              epoch_end;

   // Wipe-off of the code from the sample
   assign mag  = {sample_data[1:0], 1'b1};
   assign neg  = sample_data[2] ^ ~ca_chip;   // Flip when chip is -1
   assign prod = neg ? -$signed({1'b0, mag}) : $signed({1'b0, mag});

   assign acc_next = acc + {{(`GPS_ACC_W-4){prod[3]}}, prod};

   // Epoch end must not land on a pending dump
   assign last_chip  = (code_phase == last_phase);
   assign epoch_hold = last_chip & dump_valid;

   assign sample_ready = enable & ~seek_busy & ~clear & ~epoch_hold;
   assign advance      = sample_valid & sample_ready;
   assign epoch_end    = advance & last_chip;

   always_ff @(posedge clk_sample) begin
      if (rst) begin
         acc <= '0;
      end else if (clear || epoch_end) begin
         acc <= '0;                 // Next sample opens a new sum
      end else if (advance) begin
         acc <= acc_next;
      end
   end

   // Dump handshake held until taken
   always_ff @(posedge clk_sample) begin
      if (rst) begin
         dump_valid <= 1'b0;
      end else if (epoch_end) begin
         dump_valid <= 1'b1;        // Slot is free here by the hold rule
      end else if (dump_ready) begin
         dump_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk_sample) begin
      if (epoch_end) begin
         dump_acc <= acc_next;      // Includes the phase 1022 sample
      end
   end

endmodule

//--- ca_code_gen.sv
`timescale 1ns/1ps
`include "gps_defines.svh"

module ca_code_gen (
   input  logic            clk_sample,
   input  logic            rst,
   input  gps_pkg::prn_t   prn,          // Selected satellite
   input  logic            prn_load,     // Restart code at phase 0
   input  gps_pkg::phase_t seek_target,  // Phase to slew to
   input  logic            seek_start,   // One-cycle seek request
   input  logic            advance,      // Step one chip per accepted sample
   output logic            ca_chip,      // Code bit at code_phase
   output gps_pkg::phase_t code_phase,   // Phase of the next chip
   output logic            seek_busy,    // Slew in progress
   output logic            seek_done     // Pulse after reaching target
);

   localparam gps_pkg::phase_t last_phase = gps_pkg::phase_t'(`GPS_CODE_LEN - 1);

   logic [10:1]     g1;           // Stage 1 is the input end
   logic [10:1]     g2;
   logic            g1_fb;
   logic            g2_fb;
   logic [7:0]      taps;         // Two G2 stage numbers
   logic [3:0]      tap_a;
   logic [3:0]      tap_b;
   gps_pkg::phase_t phase_next;
   logic            seek_active;  // Stepping toward target
   logic            seeking;
   logic            at_target;
   logic            step;

   // G2 phase selector taps per PRN
   function automatic logic [7:0] g2_taps(input gps_pkg::prn_t p);
      case (p)
         5'd1:    g2_taps = {4'd2, 4'd6};
         5'd2:    g2_taps = {4'd3, 4'd7};
         5'd3:    g2_taps = {4'd4, 4'd8};
         5'd4:    g2_taps = {4'd5, 4'd9};
         5'd5:    g2_taps = {4'd1, 4'd9};
         5'd6:    g2_taps = {4'd2, 4'd10};
         5'd7:    g2_taps = {4'd1, 4'd8};
         5'd8:    g2_taps = {4'd2, 4'd9};
         5'd9:    g2_taps = {4'd3, 4'd10};
         5'd10:   g2_taps = {4'd2, 4'd3};
         5'd11:   g2_taps = {4'd3, 4'd4};
         5'd12:   g2_taps = {4'd5, 4'd6};
         5'd13:   g2_taps = {4'd6, 4'd7};
         5'd14:   g2_taps = {4'd7, 4'd8};
         5'd15:   g2_taps = {4'd8, 4'd9};
         5'd16:   g2_taps = {4'd9, 4'd10};
         5'd17:   g2_taps = {4'd1, 4'd4};
         5'd18:   g2_taps = {4'd2, 4'd5};
         5'd19:   g2_taps = {4'd3, 4'd6};
         5'd20:   g2_taps = {4'd4, 4'd7};
         5'd21:   g2_taps = {4'd5, 4'd8};
         5'd22:   g2_taps = {4'd6, 4'd9};
         5'd23:   g2_taps = {4'd1, 4'd3};
         5'd24:   g2_taps = {4'd4, 4'd6};
         5'd25:   g2_taps = {4'd5, 4'd7};
         5'd26:   g2_taps = {4'd6, 4'd8};
         5'd27:   g2_taps = {4'd7, 4'd9};
         5'd28:   g2_taps = {4'd8, 4'd10};
         5'd29:   g2_taps = {4'd1, 4'd6};
         5'd30:   g2_taps = {4'd2, 4'd7};
         5'd31:   g2_taps = {4'd3, 4'd8};
         default: g2_taps = {4'd4, 4'd9};  // PRN 32 encoded as 0
      endcase
   endfunction

   assign taps  = g2_taps(prn);
   assign tap_a = taps[7:4];
   assign tap_b = taps[3:0];

   assign g1_fb = g1[3] ^ g1[10];                                // 1 + x^3 + x^10
   assign g2_fb = g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10]; // G2 polynomial

   assign ca_chip = g1[10] ^ g2[tap_a] ^ g2[tap_b];

   assign phase_next = (code_phase == last_phase) ? '0 : code_phase + 1'b1;

   assign seeking   = seek_start | seek_active;
   assign at_target = (code_phase == seek_target);
   assign step      = advance | seeking;    // Samples are blocked while seeking
   assign seek_busy = seeking;              // Covers the request cycle too

   always_ff @(posedge clk_sample) begin
      if (rst) begin
         g1          <= '1;
         g2          <= '1;
         code_phase  <= '0;
         seek_active <= 1'b0;
         seek_done   <= 1'b0;
      end else begin
         seek_done <= 1'b0;
         if (prn_load) begin
            g1         <= '1;                // Both registers to all ones
            g2         <= '1;
            code_phase <= '0;
         end else if (seeking && at_target) begin
            seek_active <= 1'b0;             // Target already reached
            seek_done   <= 1'b1;
         end else if (step) begin
            g1         <= {g1[9:1], g1_fb};  // Back to all ones after 1023 steps
            g2         <= {g2[9:1], g2_fb};
            code_phase <= phase_next;
            if (seeking) begin
               seek_active <= (phase_next != seek_target);
               seek_done   <= (phase_next == seek_target);
            end
         end
      end
   end

endmodule

//--- subchannel_cfg.sv
`timescale 1ns/1ps
`include "gps_defines.svh"

module subchannel_cfg (
   input  logic                   clk_sample,
   input  logic                   rst,
   input  logic                   cfg_valid,
   input  logic [`GPS_CFG_AW-1:0] cfg_addr,
   input  logic [`GPS_CFG_DW-1:0] cfg_data,
   input  logic                   seek_busy,    // From code generator
   output logic                   cfg_ready,
   output gps_pkg::prn_t          prn,
   output logic                   prn_load,     // One cycle after PRN write
   output gps_pkg::phase_t        seek_target,
   output logic                   seek_start,   // One cycle after SEEK write
   output logic                   enable        // Sampling enable
);

   logic wr_accept;

   // Writes stall for the whole slew
   assign cfg_ready = ~seek_busy;
   assign wr_accept = cfg_valid & cfg_ready;

   // Held register values
   always_ff @(posedge clk_sample) begin
      if (rst) begin
         prn         <= 5'd1;     // PRN 1 out of reset
         seek_target <= '0;
         enable      <= 1'b0;
      end else if (wr_accept) begin
         case (cfg_addr)
            `GPS_REG_PRN: begin
               prn <= cfg_data[4:0];
            end
            `GPS_REG_SEEK: begin
               seek_target <= cfg_data[`GPS_PHASE_W-1:0];
            end
            `GPS_REG_CTRL: begin
               enable <= cfg_data[0];
            end
            default: begin
               // Unmapped address is dropped
            end
         endcase
      end
   end

   // Single-cycle strobes aligned with the new register values
   always_ff @(posedge clk_sample) begin
      if (rst) begin
         prn_load   <= 1'b0;
         seek_start <= 1'b0;
      end else begin
         prn_load   <= wr_accept && (cfg_addr == `GPS_REG_PRN);
         seek_start <= wr_accept && (cfg_addr == `GPS_REG_SEEK);
      end
   end

endmodule

//--- gps_pkg.sv
`include "gps_defines.svh"

package gps_pkg;

   // Satellite number where 0 encodes PRN 32
   typedef logic [4:0] prn_t;

   // Code phase of a chip within the period
   typedef logic [`GPS_PHASE_W-1:0] phase_t;

   // Bit 2 is the sign, bits 1:0 the magnitude m, value is +/-(2m+1)
   typedef logic [`GPS_SAMPLE_W-1:0] sample_t;

   // Correlation sum over one code epoch
   typedef logic signed [`GPS_ACC_W-1:0] acc_t;

endpackage

//--- gps_defines.svh
`ifndef GPS_DEFINES_SVH
`define GPS_DEFINES_SVH

// C/A code geometry
`define GPS_CODE_LEN   11'd1023  // Chips per code period
`define GPS_PHASE_W    10        // Code phase 0..1022

// Datapath widths
`define GPS_SAMPLE_W   3         // Sign bit plus 2-bit magnitude
`define GPS_ACC_W      19        // Signed epoch sum

// Configuration port
`define GPS_CFG_AW     2         // Register address
`define GPS_CFG_DW     16        // Write data

// Register map
`define GPS_REG_PRN    2'd0      // Satellite number, bits 4:0
`define GPS_REG_SEEK   2'd1      // Seek target phase, bits 9:0
`define GPS_REG_CTRL   2'd2      // Bit 0 enables sampling

`endif
